//--- project.f
+incdir+include
design/rf_types_pkg.sv
design/wb_types_pkg.sv
design/toggle_memory_set.sv
design/register_bank.sv
design/issue_stage.sv
design/register_file.sv
design/regfile_top.sv
verif/regfile_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the register file testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module regfile_tb -f project.f -o regfile_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/regfile_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only if the testbench printed its pass line
if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
else
    echo "Pass line not found in simulation output"
    exit 1
fi

//--- verif/regfile_tb.sv
////////////////////////////////////////
// Register file testbench
// Step table, shadow model, per-test summary
////////////////////////////////////////
`timescale 1ns/1ps
`include "regfile_cfg.svh"

module regfile_tb
    import rf_types_pkg::*;
    import wb_types_pkg::*;
();

    typedef enum {OP_IDLE, OP_DECODE, OP_FIRE, OP_COMMIT, OP_FLUSH, OP_CLEAR} op_e;

    // One step of the table
    typedef struct {
        int         test;
        op_e        op;
        phys_addr_t rs1;
        phys_addr_t rs2;
        phys_addr_t rd;
        wb_group_t  grp;
        logic       single;
        reg_data_t  data;
        logic       exp_ready;
        logic       chk;
    } row_t;

    logic       clk;
    logic       rst;
    logic       decode_advance;
    phys_addr_t decode_phys_rs_addr [`RF_READ_PORTS];
    wb_group_t  decode_rs_wb_group [`RF_READ_PORTS];
    phys_addr_t decode_phys_rd_addr;
    logic       decode_uses_rd;
    logic       decode_single_cycle;
    logic       issue_fire;
    logic       commit_valid [`RF_NUM_WB_GROUPS];
    phys_addr_t commit_phys_addr [`RF_NUM_WB_GROUPS];
    reg_data_t  commit_data [`RF_NUM_WB_GROUPS];
    logic       gc_fetch_flush;
    logic       gc_init_clear;
    logic       issue_valid;
    logic       issue_ready;
    reg_data_t  issue_rs_data [`RF_READ_PORTS];
    phys_addr_t issue_phys_rd_addr;

    // Shadow model: bank contents, pending bits, issue entry
    reg_data_t  mem [`RF_NUM_WB_GROUPS][`RF_NUM_PHYS_REGS];
    logic       pending [`RF_NUM_PHYS_REGS];
    logic       ent_valid;
    logic       ent_marked;
    logic       ent_single;
    phys_addr_t ent_rs [`RF_READ_PORTS];
    wb_group_t  ent_grp;
    phys_addr_t ent_rd;

    row_t       rows [$];
    int         check_count;
    int         error_count;
    int         test_errors;
    logic       timed_out;
    integer     seed;

    regfile_top u_dut (
        .clk                 (clk),
        .rst                 (rst),
        .decode_advance      (decode_advance),
        .decode_phys_rs_addr (decode_phys_rs_addr),
        .decode_rs_wb_group  (decode_rs_wb_group),
        .decode_phys_rd_addr (decode_phys_rd_addr),
        .decode_uses_rd      (decode_uses_rd),
        .decode_single_cycle (decode_single_cycle),
        .issue_fire          (issue_fire),
        .commit_valid        (commit_valid),
        .commit_phys_addr    (commit_phys_addr),
        .commit_data         (commit_data),
        .gc_fetch_flush      (gc_fetch_flush),
        .gc_init_clear       (gc_init_clear),
        .issue_valid         (issue_valid),
        .issue_ready         (issue_ready),
        .issue_rs_data       (issue_rs_data),
        .issue_phys_rd_addr  (issue_phys_rd_addr)
    );

    // 20 ns period
    always #10 clk = ~clk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Edge, then the drive point 2 ns later
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    task automatic add_row(input int test, input op_e op, input phys_addr_t rs1,
                           input phys_addr_t rs2, input phys_addr_t rd, input wb_group_t grp,
                           input logic single, input reg_data_t data, input logic exp_ready,
                           input logic chk);
        rows.push_back('{test, op, rs1, rs2, rd, grp, single, data, exp_ready, chk});
    endtask

    // Data 0 in a commit row means random data
    task automatic build_table();
        // After reset, then any sources are ready
        add_row(1, OP_IDLE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 0);
        add_row(1, OP_DECODE, 0,  0,  3, WB_SINGLE, 1, 0,            1, 0);
        add_row(1, OP_FIRE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 1);
        add_row(1, OP_DECODE, 7,  9,  0, WB_SINGLE, 0, 0,            1, 0);
        add_row(1, OP_FIRE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 0);
        // Group 0 commits read back by a later decode
        add_row(2, OP_COMMIT, 0,  0,  5, WB_SINGLE, 0, 0,            0, 0);
        add_row(2, OP_COMMIT, 0,  0,  6, WB_SINGLE, 0, 32'h1234_5678, 0, 0);
        add_row(2, OP_DECODE, 5,  6,  0, WB_SINGLE, 0, 0,            1, 0);
        add_row(2, OP_FIRE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 1);
        // Reader blocked on a multi-cycle rd, then forwarded
        add_row(3, OP_DECODE, 5,  6, 12, WB_SINGLE, 0, 0,            1, 0);
        add_row(3, OP_FIRE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 1);
        add_row(3, OP_DECODE, 12, 0,  0, WB_MULTI,  0, 0,            0, 0);
        add_row(3, OP_IDLE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 0);
        add_row(3, OP_IDLE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 0);
        add_row(3, OP_COMMIT, 0,  0, 12, WB_MULTI,  0, 0,            1, 0);
        add_row(3, OP_FIRE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 1);
        // Single-cycle fire frees its rd
        add_row(4, OP_DECODE, 5,  6, 20, WB_SINGLE, 1, 0,            1, 0);
        add_row(4, OP_FIRE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 1);
        add_row(4, OP_COMMIT, 0,  0, 20, WB_SINGLE, 0, 0,            0, 0);
        add_row(4, OP_DECODE, 20, 5,  0, WB_SINGLE, 0, 0,            1, 0);
        add_row(4, OP_FIRE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 1);
        // Flush frees the old rd and skips marking the new one
        add_row(5, OP_DECODE, 5,  6, 25, WB_SINGLE, 0, 0,            1, 0);
        add_row(5, OP_FLUSH,  5,  0, 26, WB_SINGLE, 0, 0,            1, 0);
        add_row(5, OP_FIRE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 1);
        add_row(5, OP_COMMIT, 0,  0, 25, WB_SINGLE, 0, 0,            0, 0);
        add_row(5, OP_COMMIT, 0,  0, 26, WB_SINGLE, 0, 0,            0, 0);
        add_row(5, OP_DECODE, 25, 26, 0, WB_SINGLE, 0, 0,            1, 0);
        add_row(5, OP_FIRE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 1);
        // Init clear unblocks a waiting reader
        add_row(6, OP_DECODE, 5,  6, 30, WB_SINGLE, 0, 0,            1, 0);
        add_row(6, OP_FIRE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 1);
        add_row(6, OP_DECODE, 30, 0,  0, WB_MULTI,  0, 0,            0, 0);
        add_row(6, OP_IDLE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 0);
        add_row(6, OP_CLEAR,  0,  0,  0, WB_SINGLE, 0, 0,            1, 0);
        add_row(6, OP_FIRE,   0,  0,  0, WB_SINGLE, 0, 0,            0, 0);
    endtask

    // Loop until ready, 50 cycles at most
    task automatic wait_ready(output logic ok);
        int cycles;
        cycles = 0;
        while (!issue_ready && cycles < 50) begin
            tick();
            cycles++;
        end
        ok = issue_ready;
    endtask

    // Valid and ready against model, model against table
    task automatic check_state(input int idx);
        logic model_ready;
        model_ready = ent_valid && !pending[ent_rs[RS1]] && !pending[ent_rs[RS2]];
        check_count++;
        assert (issue_valid === ent_valid && issue_ready === model_ready
                && model_ready === rows[idx].exp_ready)
        else begin
            $display("FAILED at %0t: test %0d row %0d valid %b ready %b, model %b/%b table %b",
                     $time, rows[idx].test, idx, issue_valid, issue_ready,
                     ent_valid, model_ready, rows[idx].exp_ready);
            note_error();
        end
    endtask

    task automatic check_operands(input int idx);
        reg_data_t expected;
        check_count++;
        assert (issue_phys_rd_addr === ent_rd)
        else begin
            $display("FAILED at %0t: test %0d row %0d rd %0d, expected %0d",
                     $time, rows[idx].test, idx, issue_phys_rd_addr, ent_rd);
            note_error();
        end
        if (rows[idx].chk) begin
            for (int i = 0; i < `RF_READ_PORTS; i++) begin
                expected = mem[ent_grp][ent_rs[i]];
                check_count++;
                assert (issue_rs_data[i] === expected)
                else begin
                    $display("FAILED at %0t: test %0d row %0d rs%0d data %h, expected %h",
                             $time, rows[idx].test, idx, i + 1, issue_rs_data[i], expected);
                    note_error();
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // Step driver with model update
    ////////////////////////////////////////
    task automatic apply_row(input int idx);
        row_t r;
        logic ok;
        r = rows[idx];
        case (r.op)
            OP_DECODE, OP_FLUSH: begin
                decode_advance           = 1'b1;
                decode_phys_rs_addr[RS1] = r.rs1;
                decode_phys_rs_addr[RS2] = r.rs2;
                decode_rs_wb_group[RS1]  = r.grp;
                decode_rs_wb_group[RS2]  = r.grp;
                decode_phys_rd_addr      = r.rd;
                decode_uses_rd           = (r.rd != '0);
                decode_single_cycle      = r.single;
                gc_fetch_flush           = (r.op == OP_FLUSH);
                // Flush frees the old entry's rd, new rd stays free
                if (r.op == OP_FLUSH) begin
                    if (ent_valid && ent_marked) begin
                        pending[ent_rd] = !pending[ent_rd];
                    end
                end else if (r.rd != '0) begin
                    pending[r.rd] = !pending[r.rd];
                end
                ent_valid   = 1'b1;
                ent_marked  = (r.op == OP_DECODE) && (r.rd != '0);
                ent_single  = r.single;
                ent_rs[RS1] = r.rs1;
                ent_rs[RS2] = r.rs2;
                ent_grp     = r.grp;
                ent_rd      = r.rd;
                tick();
                decode_advance = 1'b0;
                gc_fetch_flush = 1'b0;
            end
            OP_FIRE: begin
                wait_ready(ok);
                if (!ok) begin
                    $display("Timeout: issue_ready stayed low for 50 cycles in test %0d",
                             r.test);
                    timed_out = 1'b1;
                end else begin
                    check_operands(idx);
                    issue_fire = 1'b1;
                    // Single-cycle rd released on fire
                    if (ent_marked && ent_single) begin
                        pending[ent_rd] = !pending[ent_rd];
                    end
                    ent_valid = 1'b0;
                    tick();
                    issue_fire = 1'b0;
                end
            end
            OP_COMMIT: begin
                commit_valid[r.grp]     = 1'b1;
                commit_phys_addr[r.grp] = r.rd;
                commit_data[r.grp]      = (r.data == '0) ? $random(seed) : r.data;
                mem[r.grp][r.rd]        = commit_data[r.grp];
                if (r.grp == WB_MULTI) begin
                    pending[r.rd] = !pending[r.rd];
                end
                tick();
                // Data bus keeps its last value
                commit_valid[r.grp] = 1'b0;
            end
            OP_CLEAR: begin
                gc_init_clear = 1'b1;
                for (int a = 0; a < `RF_NUM_PHYS_REGS; a++) begin
                    pending[a] = 1'b0;
                end
                tick();
                gc_init_clear = 1'b0;
            end
            default: begin
                tick();
            end
        endcase
        if (!timed_out) begin
            check_state(idx);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        clk                 = 1'b0;
        rst                 = 1'b1;
        decode_advance      = 1'b0;
        decode_phys_rd_addr = '0;
        decode_uses_rd      = 1'b0;
        decode_single_cycle = 1'b0;
        issue_fire          = 1'b0;
        gc_fetch_flush      = 1'b0;
        gc_init_clear       = 1'b0;
        seed                = 32'ha6b638fd;
        check_count         = 0;
        error_count         = 0;
        test_errors         = 0;
        timed_out           = 1'b0;
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            decode_phys_rs_addr[i] = '0;
            decode_rs_wb_group[i]  = '0;
            ent_rs[i]              = '0;
        end
        for (int g = 0; g < `RF_NUM_WB_GROUPS; g++) begin
            commit_valid[g]     = 1'b0;
            commit_phys_addr[g] = '0;
            commit_data[g]      = '0;
            for (int a = 0; a < `RF_NUM_PHYS_REGS; a++) begin
                mem[g][a] = '0;
            end
        end
        for (int a = 0; a < `RF_NUM_PHYS_REGS; a++) begin
            pending[a] = 1'b0;
        end
        ent_valid  = 1'b0;
        ent_marked = 1'b0;
        ent_single = 1'b0;
        ent_grp    = '0;
        ent_rd     = '0;
        build_table();

        // 10 cycles of reset
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            if (!timed_out) begin
                apply_row(i);
            end
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
                $display("test %0d finished with %0d errors", rows[i].test, test_errors);
                test_errors = 0;
            end
        end

        $display("checks %0d, errors %0d, timeout %0d", check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- design/regfile_top.sv
////////////////////////////////////////
// Issue stage plus register file
////////////////////////////////////////
`timescale 1ns/1ps
`include "regfile_cfg.svh"

module regfile_top
    import rf_types_pkg::*;
    import wb_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // Decode
    input  logic       decode_advance,
    input  phys_addr_t decode_phys_rs_addr [`RF_READ_PORTS],
    input  wb_group_t  decode_rs_wb_group [`RF_READ_PORTS],
    input  phys_addr_t decode_phys_rd_addr,
    input  logic       decode_uses_rd,
    input  logic       decode_single_cycle,
    // Issue control
    input  logic       issue_fire,
    // Writeback, one entry per group
    input  logic       commit_valid [`RF_NUM_WB_GROUPS],
    input  phys_addr_t commit_phys_addr [`RF_NUM_WB_GROUPS],
    input  reg_data_t  commit_data [`RF_NUM_WB_GROUPS],
    // Global control
    input  logic       gc_fetch_flush,
    input  logic       gc_init_clear,
    // Issue outputs
    output logic       issue_valid,
    output logic       issue_ready,
    output reg_data_t  issue_rs_data [`RF_READ_PORTS],
    output phys_addr_t issue_phys_rd_addr
);

    phys_addr_t issue_phys_rs_addr [`RF_READ_PORTS];
    wb_group_t  issue_rs_wb_group [`RF_READ_PORTS];
    logic       issue_inuse [`RF_READ_PORTS];
    logic       single_cycle_or_flush;

    issue_stage u_issue (
        .clk                   (clk),
        .rst                   (rst),
        .decode_advance        (decode_advance),
        .decode_uses_rd        (decode_uses_rd),
        .decode_single_cycle   (decode_single_cycle),
        .issue_fire            (issue_fire),
        .gc_fetch_flush        (gc_fetch_flush),
        .decode_phys_rs_addr   (decode_phys_rs_addr),
        .decode_phys_rd_addr   (decode_phys_rd_addr),
        .decode_rs_wb_group    (decode_rs_wb_group),
        .issue_inuse           (issue_inuse),
        .issue_valid           (issue_valid),
        .issue_ready           (issue_ready),
        .single_cycle_or_flush (single_cycle_or_flush),
        .issue_phys_rs_addr    (issue_phys_rs_addr),
        .issue_phys_rd_addr    (issue_phys_rd_addr),
        .issue_rs_wb_group     (issue_rs_wb_group)
    );

    register_file u_rf (
        .clk                   (clk),
        .rst                   (rst),
        .gc_init_clear         (gc_init_clear),
        .gc_fetch_flush        (gc_fetch_flush),
        .decode_phys_rs_addr   (decode_phys_rs_addr),
        .decode_phys_rd_addr   (decode_phys_rd_addr),
        .decode_rs_wb_group    (decode_rs_wb_group),
        .decode_advance        (decode_advance),
        .decode_uses_rd        (decode_uses_rd),
        .issue_phys_rs_addr    (issue_phys_rs_addr),
        .issue_phys_rd_addr    (issue_phys_rd_addr),
        .issue_rs_wb_group     (issue_rs_wb_group),
        .single_cycle_or_flush (single_cycle_or_flush),
        .commit_valid          (commit_valid),
        .commit_phys_addr      (commit_phys_addr),
        .commit_data           (commit_data),
        .issue_inuse           (issue_inuse),
        .issue_rs_data         (issue_rs_data)
    );

endmodule

//--- design/register_file.sv
////////////////////////////////////////
// Register banks, in-use tracking, bypass muxing
// Issue operand registers
////////////////////////////////////////
`timescale 1ns/1ps
`include "regfile_cfg.svh"

module register_file
    import rf_types_pkg::*;
    import wb_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       gc_init_clear,
    input  logic       gc_fetch_flush,
    input  phys_addr_t decode_phys_rs_addr [`RF_READ_PORTS],
    input  phys_addr_t decode_phys_rd_addr,
    input  wb_group_t  decode_rs_wb_group [`RF_READ_PORTS],
    input  logic       decode_advance,
    input  logic       decode_uses_rd,
    input  phys_addr_t issue_phys_rs_addr [`RF_READ_PORTS],
    input  phys_addr_t issue_phys_rd_addr,
    input  wb_group_t  issue_rs_wb_group [`RF_READ_PORTS],
    input  logic       single_cycle_or_flush,
    input  logic       commit_valid [`RF_NUM_WB_GROUPS],
    input  phys_addr_t commit_phys_addr [`RF_NUM_WB_GROUPS],
    input  reg_data_t  commit_data [`RF_NUM_WB_GROUPS],
    output logic       issue_inuse [`RF_READ_PORTS],
    output reg_data_t  issue_rs_data [`RF_READ_PORTS]
);

    localparam int NUM_TOGGLES = 3;
    localparam int NUM_INUSE_READS = 2 * `RF_READ_PORTS;

    logic       toggle [NUM_TOGGLES];
    phys_addr_t toggle_addr [NUM_TOGGLES];
    phys_addr_t inuse_addr [NUM_INUSE_READS];
    logic       inuse [NUM_INUSE_READS];

    logic       decode_inuse [`RF_READ_PORTS];
    logic       decode_inuse_r [`RF_READ_PORTS];
    reg_data_t  bank_data [`RF_NUM_WB_GROUPS][`RF_READ_PORTS];
    wb_group_t  rs_wb_group [`RF_READ_PORTS];
    logic       bypass [`RF_READ_PORTS];

    ////////////////////////////////////////
    // In-use tracking
    ////////////////////////////////////////

    // Port 0 marks rd at decode, suppressed under flush
    assign toggle[0]      = decode_advance && decode_uses_rd && (decode_phys_rd_addr != '0)
                            && !gc_fetch_flush;
    assign toggle_addr[0] = decode_phys_rd_addr;
    // Port 1 releases single-cycle or flushed rd
    assign toggle[1]      = single_cycle_or_flush;
    assign toggle_addr[1] = issue_phys_rd_addr;
    // Port 2 releases on multi-cycle commit
    assign toggle[2]      = commit_valid[WB_MULTI];
    assign toggle_addr[2] = commit_phys_addr[WB_MULTI];

    // Reads 0..1 for decode sources, 2..3 for issue sources
    always_comb begin
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            inuse_addr[i]                  = decode_phys_rs_addr[i];
            inuse_addr[`RF_READ_PORTS + i] = issue_phys_rs_addr[i];
            decode_inuse[i]                = inuse[i];
            issue_inuse[i]                 = inuse[`RF_READ_PORTS + i];
        end
    end

    toggle_memory_set #(
        .NUM_TOGGLE_PORTS (NUM_TOGGLES),
        .NUM_READ_PORTS   (NUM_INUSE_READS)
    ) u_inuse (
        .clk         (clk),
        .rst         (rst),
        .init_clear  (gc_init_clear),
        .toggle      (toggle),
        .toggle_addr (toggle_addr),
        .read_addr   (inuse_addr),
        .in_use      (inuse)
    );

    // Decode-time pending state, kept for the waiting entry
    always_ff @(posedge clk) begin
        if (decode_advance) begin
            decode_inuse_r <= decode_inuse;
        end
    end

    ////////////////////////////////////////
    // Banks, one memory per writeback group
    ////////////////////////////////////////
    generate
        for (genvar g = 0; g < `RF_NUM_WB_GROUPS; g++) begin : gen_bank
            register_bank #(
                .NUM_READ_PORTS (`RF_READ_PORTS)
            ) u_bank (
                .clk        (clk),
                .write_addr (commit_phys_addr[g]),
                .new_data   (commit_data[g]),
                .commit     (commit_valid[g]),
                .read_addr  (decode_phys_rs_addr),
                .data       (bank_data[g])
            );
        end
    endgenerate

    ////////////////////////////////////////
    // Operand muxing
    ////////////////////////////////////////

    // Decode fields on load, issue fields while waiting
    always_comb begin
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            rs_wb_group[i] = decode_advance ? decode_rs_wb_group[i] : issue_rs_wb_group[i];
            bypass[i]      = decode_advance ? decode_inuse[i] : decode_inuse_r[i];
        end
    end

    // Keep sampling the group's commit bus until the source clears
    // Last reload happens on the releasing commit itself
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            if (decode_advance || issue_inuse[i]) begin
                issue_rs_data[i] <= bypass[i] ? commit_data[rs_wb_group[i]]
                                              : bank_data[rs_wb_group[i]][i];
            end
        end
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    // Register 0 is constant, renaming must never target it
    generate
        for (genvar g = 0; g < `RF_NUM_WB_GROUPS; g++) begin : gen_zero_chk
            assert property (@(posedge clk) disable iff (rst)
                commit_valid[g] |-> (commit_phys_addr[g] != '0))
            else
                $error("commit to physical register zero");
        end
    endgenerate

endmodule

//--- design/issue_stage.sv
////////////////////////////////////////
// One-entry issue register
// Readiness and release toggle for the destination
////////////////////////////////////////
`timescale 1ns/1ps
`include "regfile_cfg.svh"

module issue_stage
    import rf_types_pkg::*;
    import wb_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       decode_advance,
    input  logic       decode_uses_rd,
    input  logic       decode_single_cycle,
    input  logic       issue_fire,
    input  logic       gc_fetch_flush,
    input  phys_addr_t decode_phys_rs_addr [`RF_READ_PORTS],
    input  phys_addr_t decode_phys_rd_addr,
    input  wb_group_t  decode_rs_wb_group [`RF_READ_PORTS],
    input  logic       issue_inuse [`RF_READ_PORTS],
    output logic       issue_valid,
    output logic       issue_ready,
    output logic       single_cycle_or_flush,
    output phys_addr_t issue_phys_rs_addr [`RF_READ_PORTS],
    output phys_addr_t issue_phys_rd_addr,
    output wb_group_t  issue_rs_wb_group [`RF_READ_PORTS]
);

    // Destination was marked in use at decode
    logic issue_rd_marked;
    logic issue_single_cycle;

    ////////////////////////////////////////
    // Entry registers
    ////////////////////////////////////////

    // Valid flag, reload wins over fire and flush
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else if (decode_advance) begin
            issue_valid <= 1'b1;
        end else if (issue_fire || gc_fetch_flush) begin
            issue_valid <= 1'b0;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (decode_advance) begin
            issue_phys_rs_addr <= decode_phys_rs_addr;
            issue_rs_wb_group  <= decode_rs_wb_group;
            issue_phys_rd_addr <= decode_phys_rd_addr;
            issue_single_cycle <= decode_single_cycle;
            // Same condition as the decode toggle in the register file
            issue_rd_marked    <= decode_uses_rd && (decode_phys_rd_addr != '0)
                                  && !gc_fetch_flush;
        end
    end

    ////////////////////////////////////////
    // Readiness and release
    ////////////////////////////////////////

    // Both sources available
    assign issue_ready = issue_valid && !issue_inuse[RS1] && !issue_inuse[RS2];

    // Single-cycle fire or flush frees rd right away
    // Multi-cycle rd waits for its group 1 commit
    assign single_cycle_or_flush = issue_valid && issue_rd_marked &&
                                   ((issue_fire && issue_single_cycle) || gc_fetch_flush);

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    // Fire only once the register file reports both sources free
    assert property (@(posedge clk) disable iff (rst) issue_fire |-> issue_ready)
    else
        $error("issue_fire while not ready");

    // A live entry may only be replaced when it leaves this cycle
    assert property (@(posedge clk) disable iff (rst)
        decode_advance |-> (!issue_valid || issue_fire || gc_fetch_flush))
    else
        $error("decode overwrote a waiting issue entry");

endmodule

//--- design/register_bank.sv
////////////////////////////////////////
// One bank of physical registers
// Single write port, combinational read ports
////////////////////////////////////////
`timescale 1ns/1ps
`include "regfile_cfg.svh"

module register_bank
    import rf_types_pkg::*;
#(
    parameter int NUM_READ_PORTS = `RF_READ_PORTS
) (
    input  logic       clk,
    input  phys_addr_t write_addr,
    input  reg_data_t  new_data,
    input  logic       commit,
    input  phys_addr_t read_addr [NUM_READ_PORTS],
    output reg_data_t  data [NUM_READ_PORTS]
);

    // Register storage, maps to distributed RAM
    reg_data_t regs [`RF_NUM_PHYS_REGS];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    // Lands on the edge of the commit cycle
    always_ff @(posedge clk) begin
        if (commit) begin
            regs[write_addr] <= new_data;
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // Old value in a write cycle
    // Entry 0 forced to zero, its storage is never written
    always_comb begin
        for (int i = 0; i < NUM_READ_PORTS; i++) begin
            if (read_addr[i] == '0) begin
                data[i] = '0;
            end else begin
                data[i] = regs[read_addr[i]];
            end
        end
    end

endmodule

//--- design/toggle_memory_set.sv
////////////////////////////////////////
// In-use tracker from per-port toggle bits
////////////////////////////////////////
`timescale 1ns/1ps
`include "regfile_cfg.svh"

module toggle_memory_set
    import rf_types_pkg::*;
#(
    parameter int NUM_TOGGLE_PORTS = 3,
    parameter int NUM_READ_PORTS = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       init_clear,
    input  logic       toggle [NUM_TOGGLE_PORTS],
    input  phys_addr_t toggle_addr [NUM_TOGGLE_PORTS],
    input  phys_addr_t read_addr [NUM_READ_PORTS],
    output logic       in_use [NUM_READ_PORTS]
);

    // One bit per physical register, per toggle port
    logic [`RF_NUM_PHYS_REGS-1:0] toggle_bits [NUM_TOGGLE_PORTS];

    ////////////////////////////////////////
    // Toggle arrays
    ////////////////////////////////////////

    // Each port flips only its own array
    // No write collisions between ports
    generate
        for (genvar p = 0; p < NUM_TOGGLE_PORTS; p++) begin : gen_toggle_port
            always_ff @(posedge clk) begin
                if (rst || init_clear) begin
                    // Clear everything, nothing pending
                    toggle_bits[p] <= '0;
                end else if (toggle[p]) begin
                    toggle_bits[p][toggle_addr[p]] <= ~toggle_bits[p][toggle_addr[p]];
                end
            end
        end
    endgenerate

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // In use when odd number of ports flipped the bit
    // Combinational, sees state from previous edges only
    always_comb begin
        for (int r = 0; r < NUM_READ_PORTS; r++) begin
            in_use[r] = 1'b0;
            for (int p = 0; p < NUM_TOGGLE_PORTS; p++) begin
                in_use[r] = in_use[r] ^ toggle_bits[p][read_addr[r]];
            end
        end
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    // Two toggles of one address in a cycle would cancel out
    generate
        for (genvar a = 0; a < NUM_TOGGLE_PORTS; a++) begin : gen_chk_a
            for (genvar b = a + 1; b < NUM_TOGGLE_PORTS; b++) begin : gen_chk_b
                assert property (@(posedge clk) disable iff (rst)
                    !(toggle[a] && toggle[b] && (toggle_addr[a] == toggle_addr[b])))
                else
                    $error("two toggle ports hit one address in the same cycle");
            end
        end
    endgenerate

endmodule

//--- design/wb_types_pkg.sv
////////////////////////////////////////
// Writeback group select and group names
////////////////////////////////////////
`include "regfile_cfg.svh"

package wb_types_pkg;

    // Selects one writeback group
    typedef logic [$clog2(`RF_NUM_WB_GROUPS)-1:0] wb_group_t;

    // Group names
    typedef enum logic {
        WB_SINGLE = 1'b0,
        WB_MULTI  = 1'b1
    } wb_group_e;

endpackage

//--- design/rf_types_pkg.sv
////////////////////////////////////////
// Physical register addressing and data types
////////////////////////////////////////
`include "regfile_cfg.svh"

package rf_types_pkg;

    // Physical register index
    // Address 0 is the constant-zero register
    typedef logic [$clog2(`RF_NUM_PHYS_REGS)-1:0] phys_addr_t;

    // One register value
    typedef logic [`RF_XLEN-1:0] reg_data_t;

    // Read port names
    typedef enum logic {
        RS1 = 1'b0,
        RS2 = 1'b1
    } rs_index_e;

endpackage

//--- include/regfile_cfg.svh
////////////////////////////////////////
// Register file sizing macros
// Physical registers, read ports, writeback groups, data width
////////////////////////////////////////
`ifndef REGFILE_CFG_SVH
`define REGFILE_CFG_SVH

// Physical register count, entry 0 reads as zero
`define RF_NUM_PHYS_REGS 64

// Source operands per instruction (rs1, rs2)
`define RF_READ_PORTS 2

// Writeback groups
// Group 0 single-cycle results, group 1 multi-cycle results
`define RF_NUM_WB_GROUPS 2

// Register width
`define RF_XLEN 32

`endif
